/* rtl/video_pkg.sv */
// --------------------
// pixel stream types shared by the video blocks
// column and line indices along the stream
// --------------------
`default_nettype none

package video_pkg;

    // --------------------
    // geometry
    // --------------------
    localparam int LINE_POS_W = 16;

    // column or line index, counted from 0
    typedef logic [LINE_POS_W-1:0] line_pos_t;

endpackage

`default_nettype wire

/* rtl/scaler_cfg_pkg.sv */
// --------------------
// scale step format for the downscaler
// unsigned fixed point, 12 fraction bits, 4096 = 1.0
// --------------------
`default_nettype none

package scaler_cfg_pkg;

    localparam int STEP_W      = 16;
    localparam int STEP_FRAC_W = 12;
    localparam int POS_INT_W   = 16;    // integer part of an accumulated position

    typedef logic [STEP_W-1:0]                  step_t;
    typedef logic [POS_INT_W+STEP_FRAC_W-1:0]   pos_t;

    // smallest legal step, no upscaling
    localparam step_t STEP_ONE = step_t'(1 << STEP_FRAC_W);

endpackage

`default_nettype wire

/* rtl/lerp_unit.sv */
// --------------------
// weighted blend a*(1-c) + b*c, two pipeline stages
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lerp_unit #(
    parameter int PIXEL_WIDTH = 12,
    parameter int COE_WIDTH   = 10
) (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire [PIXEL_WIDTH-1:0]   a_i,
    input  wire [PIXEL_WIDTH-1:0]   b_i,
    input  wire [COE_WIDTH-1:0]     coe_i,
    input  wire                     valid_i,
    output logic [PIXEL_WIDTH-1:0]  pix_o,
    output logic                    valid_o
);

    localparam int PROD_W = PIXEL_WIDTH + COE_WIDTH + 1;

    logic [COE_WIDTH:0]  wt_a;     // 2^COE_WIDTH - c
    logic [PROD_W-1:0]   prod_a;
    logic [PROD_W-1:0]   prod_b;
    logic [PROD_W-1:0]   sum;
    logic                vld_s1;

    assign wt_a = {1'b1, {COE_WIDTH{1'b0}}} - {1'b0, coe_i};
    assign sum  = prod_a + prod_b;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_s1  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            vld_s1  <= valid_i;
            valid_o <= vld_s1;
        end
    end

    // --------------------
    // stage 1 products, stage 2 sum and truncate
    // --------------------
    always_ff @(posedge clk) begin
        prod_a <= PROD_W'(a_i) * PROD_W'(wt_a);
        prod_b <= PROD_W'(b_i) * PROD_W'(coe_i);
        pix_o  <= sum[COE_WIDTH +: PIXEL_WIDTH];
    end

endmodule

`default_nettype wire

/* rtl/line_store.sv */
// --------------------
// one-line pixel memory, read before write
// rdata shows the old word one cycle after the address
// --------------------
`timescale 1ns/1ps
`default_nettype none

module line_store #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  wire                         clk,
    input  wire video_pkg::line_pos_t   addr_i,
    input  wire                         wr_i,
    input  wire [PIXEL_WIDTH-1:0]       wdata_i,
    output logic [PIXEL_WIDTH-1:0]      rdata_o
);

    localparam int AW = $clog2(LINE_IN_SIZE_MAX);

    logic [PIXEL_WIDTH-1:0] mem [LINE_IN_SIZE_MAX];
    logic [AW-1:0]          addr;

    assign addr = addr_i[AW-1:0];   // columns past the depth wrap

    always_ff @(posedge clk) begin
        rdata_o <= mem[addr];
        if (wr_i)
            mem[addr] <= wdata_i;
    end

endmodule

`default_nettype wire

/* rtl/scaler_h.sv */
// --------------------
// horizontal linear downscaler, one output pixel per completed position
// latency 3 cycles, strobes delayed to match
// --------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_h #(
    parameter int PIXEL_WIDTH = 12,
    parameter int COE_WIDTH   = 10
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire scaler_cfg_pkg::step_t  step_i,
    input  wire [PIXEL_WIDTH-1:0]       pix_i,
    input  wire                         de_i,
    input  wire                         line_start_i,
    input  wire                         frame_start_i,
    output logic [PIXEL_WIDTH-1:0]      pix_o,
    output logic                        de_o,
    output logic                        line_start_o,
    output logic                        frame_start_o
);

    localparam int FW    = scaler_cfg_pkg::STEP_FRAC_W;
    localparam int POS_W = $bits(scaler_cfg_pkg::pos_t);

    scaler_cfg_pkg::pos_t   pos;        // position of the next output pixel
    video_pkg::line_pos_t   col;        // input column
    video_pkg::line_pos_t   pos_int;
    logic                   hit;
    logic [PIXEL_WIDTH-1:0] prev_pix;
    logic [PIXEL_WIDTH-1:0] blend_a;
    logic [PIXEL_WIDTH-1:0] blend_b;
    logic [COE_WIDTH-1:0]   blend_coe;
    logic                   blend_vld;
    logic [2:0]             ls_dly;
    logic [2:0]             fs_dly;

    assign pos_int = pos[POS_W-1:FW];

    // pixel j closes output k once floor(pos) reaches j-1
    assign hit = de_i && (col != '0) && (pos_int == col - video_pkg::line_pos_t'(1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pos       <= '0;
            col       <= '0;
            blend_vld <= 1'b0;
            ls_dly    <= '0;
            fs_dly    <= '0;
        end else begin
            blend_vld <= hit;
            if (line_start_i) begin
                pos <= '0;
                col <= '0;
            end else if (de_i) begin
                col <= col + video_pkg::line_pos_t'(1);
                if (hit)
                    pos <= pos + scaler_cfg_pkg::pos_t'(step_i);
            end
            ls_dly <= {ls_dly[1:0], line_start_i};
            fs_dly <= {fs_dly[1:0], frame_start_i};
        end
    end

    always_ff @(posedge clk) begin
        if (de_i)
            prev_pix <= pix_i;
        blend_a   <= prev_pix;
        blend_b   <= pix_i;
        blend_coe <= pos[FW-1 -: COE_WIDTH];   // top bits of the fraction
    end

    assign line_start_o  = ls_dly[2];
    assign frame_start_o = fs_dly[2];

    lerp_unit #(
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .COE_WIDTH   (COE_WIDTH)
    ) u_lerp (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .a_i      (blend_a),
        .b_i      (blend_b),
        .coe_i    (blend_coe),
        .valid_i  (blend_vld),
        .pix_o    (pix_o),
        .valid_o  (de_o)
    );

endmodule

`default_nettype wire

/* rtl/scaler_v.sv */
// --------------------
// vertical linear downscaler, blends stored line n-1 with incoming line n
// latency 4 cycles, every incoming line goes to the line store
// --------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_v #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int COE_WIDTH        = 10,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire scaler_cfg_pkg::step_t  step_i,
    input  wire [PIXEL_WIDTH-1:0]       pix_i,
    input  wire                         de_i,
    input  wire                         line_start_i,
    input  wire                         frame_start_i,
    output logic [PIXEL_WIDTH-1:0]      pix_o,
    output logic                        de_o,
    output logic                        line_start_o,
    output logic                        frame_start_o
);

    localparam int FW    = scaler_cfg_pkg::STEP_FRAC_W;
    localparam int POS_W = $bits(scaler_cfg_pkg::pos_t);

    scaler_cfg_pkg::pos_t   vpos;           // position of the next output line
    video_pkg::line_pos_t   line_cnt;       // lines seen since frame start
    video_pkg::line_pos_t   col;
    video_pkg::line_pos_t   vpos_int;
    logic                   line_emits;
    logic                   emit_line;      // current line produces pixels
    logic [COE_WIDTH-1:0]   coe_line;
    logic                   blend_vld;
    logic [COE_WIDTH-1:0]   blend_coe;
    logic [PIXEL_WIDTH-1:0] cur_pix;
    logic [PIXEL_WIDTH-1:0] prev_line_pix;
    logic [PIXEL_WIDTH-1:0] lerp_pix;
    logic                   lerp_vld;
    logic [3:0]             ls_dly;
    logic [3:0]             fs_dly;

    assign vpos_int   = vpos[POS_W-1:FW];
    assign line_emits = (line_cnt != '0) &&
                        (vpos_int == line_cnt - video_pkg::line_pos_t'(1));

    // --------------------
    // line and column tracking
    // --------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vpos      <= '0;
            line_cnt  <= '0;
            emit_line <= 1'b0;
            col       <= '0;
            blend_vld <= 1'b0;
            de_o      <= 1'b0;
            ls_dly    <= '0;
            fs_dly    <= '0;
        end else begin
            if (frame_start_i) begin
                vpos      <= '0;
                line_cnt  <= '0;
                emit_line <= 1'b0;
            end else if (line_start_i) begin
                emit_line <= line_emits;    // decided once per line
                line_cnt  <= line_cnt + video_pkg::line_pos_t'(1);
                if (line_emits)
                    vpos <= vpos + scaler_cfg_pkg::pos_t'(step_i);
            end
            if (line_start_i)
                col <= '0;
            else if (de_i)
                col <= col + video_pkg::line_pos_t'(1);
            blend_vld <= de_i & emit_line;  // aligned with the memory read
            de_o      <= lerp_vld;
            ls_dly    <= {ls_dly[2:0], line_start_i};
            fs_dly    <= {fs_dly[2:0], frame_start_i};
        end
    end

    always_ff @(posedge clk) begin
        if (line_start_i)
            coe_line <= vpos[FW-1 -: COE_WIDTH];
        blend_coe <= coe_line;
        cur_pix   <= pix_i;
        pix_o     <= lerp_pix;
    end

    assign line_start_o  = ls_dly[3];
    assign frame_start_o = fs_dly[3];

    // --------------------
    // previous line and blend
    // --------------------
    line_store #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX)
    ) u_line_store (
        .clk     (clk),
        .addr_i  (col),
        .wr_i    (de_i),
        .wdata_i (pix_i),
        .rdata_o (prev_line_pix)
    );

    lerp_unit #(
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .COE_WIDTH   (COE_WIDTH)
    ) u_lerp (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .a_i      (prev_line_pix),
        .b_i      (cur_pix),
        .coe_i    (blend_coe),
        .valid_i  (blend_vld),
        .pix_o    (lerp_pix),
        .valid_o  (lerp_vld)
    );

endmodule

`default_nettype wire

/* rtl/scaler.sv */
// --------------------
// streaming video downscaler, top level
// sync edges become strobes, steps latch per frame, then h and v stages
// --------------------
`timescale 1ns/1ps
`default_nettype none

module scaler #(
    parameter int PIXEL_WIDTH      = 12,
    parameter int COE_WIDTH        = 10,
    parameter int LINE_IN_SIZE_MAX = 1024
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire scaler_cfg_pkg::step_t  h_step_i,
    input  wire scaler_cfg_pkg::step_t  v_step_i,
    input  wire [PIXEL_WIDTH-1:0]       pix_i,
    input  wire                         de_i,
    input  wire                         hs_i,
    input  wire                         vs_i,
    output logic [PIXEL_WIDTH-1:0]      pix_o,
    output logic                        de_o,
    output logic                        hs_o,
    output logic                        vs_o
);

    logic                   hs_r1;
    logic                   hs_r2;
    logic                   vs_r1;
    logic                   vs_r2;
    logic                   de_r1;
    logic                   de_r2;
    logic [PIXEL_WIDTH-1:0] pix_r1;
    logic [PIXEL_WIDTH-1:0] pix_r2;
    logic                   line_start;    // hsync falling edge
    logic                   frame_start;   // vsync rising edge

    scaler_cfg_pkg::step_t  h_step;
    scaler_cfg_pkg::step_t  v_step;

    logic [PIXEL_WIDTH-1:0] h_pix;
    logic                   h_de;
    logic                   h_line_start;
    logic                   h_frame_start;

    // --------------------
    // input regs and sync edge detect
    // --------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hs_r1       <= 1'b0;
            hs_r2       <= 1'b0;
            vs_r1       <= 1'b0;
            vs_r2       <= 1'b0;
            de_r1       <= 1'b0;
            de_r2       <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hs_r1       <= hs_i;
            hs_r2       <= hs_r1;
            vs_r1       <= vs_i;
            vs_r2       <= vs_r1;
            de_r1       <= de_i;
            de_r2       <= de_r1;
            line_start  <= hs_r2 & ~hs_r1;
            frame_start <= ~vs_r2 & vs_r1;
        end
    end

    always_ff @(posedge clk) begin
        pix_r1 <= pix_i;
        pix_r2 <= pix_r1;   // lines up with the strobes
    end

    // steps held for the whole frame, clamped to 1.0
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_step <= scaler_cfg_pkg::STEP_ONE;
            v_step <= scaler_cfg_pkg::STEP_ONE;
        end else if (frame_start) begin
            h_step <= (h_step_i < scaler_cfg_pkg::STEP_ONE) ? scaler_cfg_pkg::STEP_ONE : h_step_i;
            v_step <= (v_step_i < scaler_cfg_pkg::STEP_ONE) ? scaler_cfg_pkg::STEP_ONE : v_step_i;
        end
    end

    // --------------------
    // scaling stages
    // --------------------
    scaler_h #(
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .COE_WIDTH   (COE_WIDTH)
    ) u_scaler_h (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .step_i        (h_step),
        .pix_i         (pix_r2),
        .de_i          (de_r2),
        .line_start_i  (line_start),
        .frame_start_i (frame_start),
        .pix_o         (h_pix),
        .de_o          (h_de),
        .line_start_o  (h_line_start),
        .frame_start_o (h_frame_start)
    );

    scaler_v #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .COE_WIDTH        (COE_WIDTH),
        .LINE_IN_SIZE_MAX (LINE_IN_SIZE_MAX)
    ) u_scaler_v (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .step_i        (v_step),
        .pix_i         (h_pix),
        .de_i          (h_de),
        .line_start_i  (h_line_start),
        .frame_start_i (h_frame_start),
        .pix_o         (pix_o),
        .de_o          (de_o),
        .line_start_o  (hs_o),
        .frame_start_o (vs_o)
    );

endmodule

`default_nettype wire

/* sim/scaler_assertions.sv */
// --------------------
// output protocol assertions, bound into the scaler top level
// --------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_assertions #(
    parameter int PIXEL_WIDTH = 12
) (
    input wire                   clk,
    input wire                   arst_n_i,
    input wire [PIXEL_WIDTH-1:0] pix_out_i,
    input wire                   de_out_i,
    input wire                   hs_out_i,
    input wire                   vs_out_i
);

    int fail_cnt = 0;   // failed assertions so far

    vs_single: assert property (@(posedge clk) disable iff (!arst_n_i) vs_out_i |=> !vs_out_i)
        else begin
            $error("vs_o high for more than one cycle");
            fail_cnt++;
        end

    hs_single: assert property (@(posedge clk) disable iff (!arst_n_i) hs_out_i |=> !hs_out_i)
        else begin
            $error("hs_o high for more than one cycle");
            fail_cnt++;
        end

    // line start never carries a pixel
    no_de_at_hs: assert property (@(posedge clk) disable iff (!arst_n_i) !(de_out_i && hs_out_i))
        else begin
            $error("de_o and hs_o high in the same cycle");
            fail_cnt++;
        end

    pix_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        de_out_i |-> !$isunknown(pix_out_i))
        else begin
            $error("pix_o has unknown bits while de_o is high");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* sim/scaler_checker.sv */
// --------------------
// captures input frames, builds the expected output stream per frame
// and compares it in order with what the scaler emits
// --------------------
`timescale 1ns/1ps
`default_nettype none

module scaler_checker #(
    parameter int PIXEL_WIDTH = 12,
    parameter int COE_WIDTH   = 10
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire scaler_cfg_pkg::step_t  h_step_i,
    input  wire scaler_cfg_pkg::step_t  v_step_i,
    input  wire [PIXEL_WIDTH-1:0]       pix_i,
    input  wire                         de_i,
    input  wire                         hs_i,
    input  wire                         vs_i,
    input  wire [PIXEL_WIDTH-1:0]       pix_out_i,
    input  wire                         de_out_i,
    input  wire                         hs_out_i,
    input  wire                         vs_out_i,
    input  wire                         flush_i,    // closes the frame in progress
    output logic                        idle_o,
    output int                          err_cnt_o
);

    localparam int FW     = scaler_cfg_pkg::STEP_FRAC_W;
    localparam int EV_VS  = 1 << 16;    // event tags above the pixel bits
    localparam int EV_HS  = 2 << 16;
    localparam int EV_PIX = 3 << 16;

    int   in_q[$];      // pixels of the frame being received
    int   line_off[$];
    int   exp_q[$];
    int   out_q[$];
    int   h_step;
    int   v_step;
    int   errors     = 0;
    logic hs_d       = 1'b0;
    logic vs_d       = 1'b0;
    logic in_frame   = 1'b0;
    logic seen_frame = 1'b0;
    video_pkg::line_pos_t out_col = '0;   // pixels since the last hs_o

    assign err_cnt_o = errors;

    // --------------------
    // reference model
    // --------------------
    function automatic int clamp_step(int s);
        return (s < scaler_cfg_pkg::STEP_ONE) ? int'(scaler_cfg_pkg::STEP_ONE) : s;
    endfunction

    // top COE_WIDTH bits of the fraction, truncated result
    function automatic int blend(int a, int b, int pos);
        int c;
        c = (pos % (1 << FW)) >> (FW - COE_WIDTH);
        return (a * ((1 << COE_WIDTH) - c) + b * c) >> COE_WIDTH;
    endfunction

    function automatic string ev_name(int ev);
        case (ev >> 16)
            1:       return "vs_o";
            2:       return "hs_o";
            default: return "de_o pixel";
        endcase
    endfunction

    task automatic expect_frame();
        int w;
        int ws;
        int n_lines;
        int row;
        int k;
        int m;
        int src;
        int sc[$];  // horizontally scaled lines, flattened
        n_lines = line_off.size();
        w = (n_lines > 0) ? in_q.size() / n_lines : 0;
        ws = 0;
        while (((ws * h_step) >> FW) + 1 < w)
            ws++;
        for (row = 0; row < n_lines; row++) begin
            for (k = 0; k < ws; k++) begin
                src = row * w + ((k * h_step) >> FW);
                sc.push_back(blend(in_q[src], in_q[src + 1], k * h_step));
            end
        end
        exp_q.push_back(EV_VS);
        m = 0;
        for (row = 0; row < n_lines; row++) begin
            exp_q.push_back(EV_HS);     // every scaled line gets hs_o
            if (row > 0 && ((m * v_step) >> FW) == row - 1) begin
                for (k = 0; k < ws; k++)
                    exp_q.push_back(EV_PIX | blend(sc[(row - 1) * ws + k],
                                                   sc[row * ws + k], m * v_step));
                m++;
            end
        end
        in_q.delete();
        line_off.delete();
    endtask

    task automatic compare_event(int exp_ev, int got_ev);
        if ((exp_ev >> 16) != (got_ev >> 16)) begin
            $display("output order wrong at %0t: got %s, expected %s",
                     $time, ev_name(got_ev), ev_name(exp_ev));
            errors++;
        end else if (got_ev != exp_ev) begin
            $display("FAIL t=%0t pix_o got %0d expected %0d (pixel %0d of its line)",
                     $time, got_ev & 16'hffff, exp_ev & 16'hffff, out_col);
            errors++;
        end
        if (got_ev == EV_HS)
            out_col = '0;
        else if ((got_ev >> 16) == 3)
            out_col++;
    endtask

    // --------------------
    // capture and compare
    // --------------------
    always @(posedge clk) begin
        if (!seen_frame && (de_out_i !== 1'b0 || hs_out_i !== 1'b0 || vs_out_i !== 1'b0)) begin
            $display("output strobe not low at %0t before any frame start", $time);
            errors++;
        end
        if (arst_n_i) begin
            if (vs_i && !vs_d) begin    // steps of the new frame
                if (in_frame)
                    expect_frame();
                h_step     = clamp_step(h_step_i);
                v_step     = clamp_step(v_step_i);
                in_frame   = 1'b1;
                seen_frame = 1'b1;
            end
            if (!hs_i && hs_d && in_frame)
                line_off.push_back(in_q.size());
            if (de_i && in_frame && line_off.size() > 0)
                in_q.push_back(pix_i);
            if (flush_i && in_frame) begin
                expect_frame();
                in_frame = 1'b0;
            end
        end
        hs_d <= hs_i;
        vs_d <= vs_i;

        if (vs_out_i)
            out_q.push_back(EV_VS);
        if (hs_out_i)
            out_q.push_back(EV_HS);
        if (de_out_i)
            out_q.push_back(EV_PIX | int'(pix_out_i));
        while (exp_q.size() > 0 && out_q.size() > 0)
            compare_event(exp_q.pop_front(), out_q.pop_front());
        idle_o <= (exp_q.size() == 0) && (out_q.size() == 0);
    end

endmodule

`default_nettype wire

/* sim/tb_scaler.sv */
// --------------------
// scaler testbench, LFSR pixel frames with several step settings
// checking in scaler_checker, protocol assertions bound into the DUT
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_scaler;

    localparam int PIXEL_WIDTH   = 12;
    localparam int COE_WIDTH     = 10;
    localparam int DRAIN_TIMEOUT = 2000;   // cycles

    logic                   clk = 1'b0;
    logic                   arst_n;
    scaler_cfg_pkg::step_t  h_step;
    scaler_cfg_pkg::step_t  v_step;
    logic [PIXEL_WIDTH-1:0] pix_in;
    logic                   de_in;
    logic                   hs_in;
    logic                   vs_in;
    logic [PIXEL_WIDTH-1:0] pix_out;
    logic                   de_out;
    logic                   hs_out;
    logic                   vs_out;
    logic                   flush;
    logic                   idle;
    int                     check_errors;
    int                     assert_errors;
    int                     timeouts = 0;
    logic [31:0]            lfsr_state = 32'h941dc86c;

    always #5 clk = ~clk;

    scaler #(
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .COE_WIDTH   (COE_WIDTH)
    ) dut0 (
        .clk      (clk),
        .arst_n_i (arst_n),
        .h_step_i (h_step),
        .v_step_i (v_step),
        .pix_i    (pix_in),
        .de_i     (de_in),
        .hs_i     (hs_in),
        .vs_i     (vs_in),
        .pix_o    (pix_out),
        .de_o     (de_out),
        .hs_o     (hs_out),
        .vs_o     (vs_out)
    );

    scaler_checker #(
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .COE_WIDTH   (COE_WIDTH)
    ) u_check (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .h_step_i  (h_step),
        .v_step_i  (v_step),
        .pix_i     (pix_in),
        .de_i      (de_in),
        .hs_i      (hs_in),
        .vs_i      (vs_in),
        .pix_out_i (pix_out),
        .de_out_i  (de_out),
        .hs_out_i  (hs_out),
        .vs_out_i  (vs_out),
        .flush_i   (flush),
        .idle_o    (idle),
        .err_cnt_o (check_errors)
    );

    bind scaler scaler_assertions #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_assert (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .pix_out_i (pix_o),
        .de_out_i  (de_o),
        .hs_out_i  (hs_o),
        .vs_out_i  (vs_o)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_pixel(output logic [PIXEL_WIDTH-1:0] p);
        int i;
        p = '0;
        for (i = 0; i < PIXEL_WIDTH; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            p = {p[PIXEL_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic tick(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // second step pair is applied halfway through the frame
    task automatic send_frame(int w, int n_lines, int h0, int v0, int h1, int v1);
        logic [PIXEL_WIDTH-1:0] p;
        int row;
        int c;
        h_step = h0;
        v_step = v0;
        vs_in  = 1'b1;
        tick(3);
        vs_in  = 1'b0;
        tick(4);
        for (row = 0; row < n_lines; row++) begin
            if (row == n_lines / 2) begin
                h_step = h1;
                v_step = v1;
            end
            hs_in = 1'b1;
            tick(2);
            hs_in = 1'b0;   // falling edge starts the line
            tick(3);
            for (c = 0; c < w; c++) begin
                random_pixel(p);
                pix_in = p;
                de_in  = 1'b1;
                tick(1);
            end
            de_in = 1'b0;
            tick(4);
        end
        tick(20);
    endtask

    task automatic wait_drain();
        int i;
        for (i = 0; i < DRAIN_TIMEOUT; i++) begin
            if (idle === 1'b1)
                break;
            tick(1);
        end
        if (idle !== 1'b1) begin
            $display("timed out after %0d cycles waiting for the DUT outputs to drain",
                     DRAIN_TIMEOUT);
            timeouts++;
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        arst_n = 1'b0;
        h_step = 16'd4096;
        v_step = 16'd4096;
        pix_in = '0;
        de_in  = 1'b0;
        hs_in  = 1'b0;
        vs_in  = 1'b0;
        flush  = 1'b0;
        tick(16);
        arst_n = 1'b1;
        tick(20);   // outputs must stay quiet here
        send_frame(12, 6, 4096, 4096, 4096, 4096);
        send_frame(16, 8, 8192, 12288, 8192, 12288);
        send_frame(20, 10, 6144, 5461, 16383, 8192);
        send_frame(20, 10, 16383, 8192, 16383, 8192);
        send_frame(14, 6, 1000, 1000, 1000, 1000);
        send_frame(24, 9, 4096, 16383, 4096, 16383);
        flush = 1'b1;
        tick(1);
        flush = 1'b0;
        wait_drain();
        assert_errors = dut0.u_assert.fail_cnt;
        $display("errors: checker %0d, assertions %0d, timeouts %0d",
                 check_errors, assert_errors, timeouts);
        if (check_errors == 0 && assert_errors == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/video_pkg.sv
rtl/scaler_cfg_pkg.sv
rtl/lerp_unit.sv
rtl/line_store.sv
rtl/scaler_h.sv
rtl/scaler_v.sv
rtl/scaler.sv
sim/scaler_assertions.sv
sim/scaler_checker.sv
sim/tb_scaler.sv

/* Bender.yml */
package:
  name: video_scaler

sources:
  - rtl/video_pkg.sv
  - rtl/scaler_cfg_pkg.sv
  - rtl/lerp_unit.sv
  - rtl/line_store.sv
  - rtl/scaler_h.sv
  - rtl/scaler_v.sv
  - rtl/scaler.sv
  - target: simulation
    files:
      - sim/scaler_assertions.sv
      - sim/scaler_checker.sv
      - sim/tb_scaler.sv
